// File: bench/ccu_tb.sv
// Testbench for the configuration control unit
// RAM model accepts one address at a time and answers after 0 to 4 idle cycles
// Images hold enough words of each opcode for every configuration of a run

`timescale 1ns/1ps
`include "ccu_defines.svh"

module ccu_tb;

    localparam int NE        = `CCU_NUM_ENG;
    localparam int NW        = `CCU_CFG_WORDS;
    localparam int AW        = `CCU_ISA_ADDR_W;
    localparam int DW        = `CCU_ISA_WORD_W;
    localparam int OW        = `CCU_OPCODE_W;
    localparam int PW        = `CCU_PAYLOAD_W;
    localparam int CNT_W     = `CCU_CNT_W;
    localparam int CFG_W     = NW * PW;
    localparam int DEPTH     = 1 << AW;
    localparam int NUM_TESTS = 5;
    localparam int TEST_CNT [NUM_TESTS] = '{3, 0, 6, 2, 5};

    logic                        clk;
    logic                        rst_n;
    logic                        start_i;
    logic                        net_done_o;
    logic [AW-1:0]               isa_rd_addr_o;
    logic                        isa_rd_addr_vld_o;
    logic                        isa_rd_addr_rdy_i = 1'b0;
    logic [DW-1:0]               isa_rd_dat_i      = '0;
    logic                        isa_rd_dat_vld_i  = 1'b0;
    logic                        isa_rd_dat_rdy_o;
    logic [AW-1:0]               isa_rd_addr_min_o;
    logic                        eng_rst_o;
    logic [NE-1:0]               cfg_vld_o;
    logic [NE-1:0]               cfg_rdy_i         = '0;
    logic [NE-1:0][CFG_W-1:0]    cfg_data_o;

    logic [DW-1:0]  img [DEPTH];     // Instruction RAM image
    int             errors    = 0;
    int             cur_cnt   = 0;   // Header count of the running test
    logic           ram_pending = 1'b0;
    logic [AW-1:0]  pend_addr = '0;
    int             lat_left  = 0;
    // Scoreboard state
    logic [AW-1:0]  sb_ptr [NE];
    logic [AW-1:0]  sb_min;
    int             scan [NE];
    int             handoffs   = 0;
    int             cur_eng    = 0;
    int             cand_q     = -1;
    logic           need_grant = 1'b0;
    logic           hdr_wait   = 1'b0;
    logic           prev_addr_vld = 1'b0;
    logic [NE-1:0]  prev_cfg_vld  = '0;

    ccu_top dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .start_i           (start_i),
        .net_done_o        (net_done_o),
        .isa_rd_addr_o     (isa_rd_addr_o),
        .isa_rd_addr_vld_o (isa_rd_addr_vld_o),
        .isa_rd_addr_rdy_i (isa_rd_addr_rdy_i),
        .isa_rd_dat_i      (isa_rd_dat_i),
        .isa_rd_dat_vld_i  (isa_rd_dat_vld_i),
        .isa_rd_dat_rdy_o  (isa_rd_dat_rdy_o),
        .isa_rd_addr_min_o (isa_rd_addr_min_o),
        .eng_rst_o         (eng_rst_o),
        .cfg_vld_o         (cfg_vld_o),
        .cfg_rdy_i         (cfg_rdy_i),
        .cfg_data_o        (cfg_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ============================================================
    // RAM and engine models
    // ============================================================
    always @(posedge clk) begin : ram_model
        logic          a_hs;
        logic          d_hs;
        logic [AW-1:0] a_addr;
        a_hs   = isa_rd_addr_vld_o && isa_rd_addr_rdy_i;
        d_hs   = isa_rd_dat_vld_i && isa_rd_dat_rdy_o;
        a_addr = isa_rd_addr_o;
        #2;
        if (d_hs) begin
            isa_rd_dat_vld_i = 1'b0;
            ram_pending      = 1'b0;
        end
        if (a_hs) begin
            ram_pending = 1'b1;
            pend_addr   = a_addr;
            lat_left    = $urandom_range(4, 0);
        end
        if (ram_pending && !isa_rd_dat_vld_i) begin
            if (lat_left == 0) begin
                isa_rd_dat_vld_i = 1'b1;
                isa_rd_dat_i     = img[pend_addr];
            end else begin
                lat_left--;
            end
        end
        isa_rd_addr_rdy_i = ($urandom_range(2, 0) != 0);
    end

    always @(posedge clk) begin
        #2;
        cfg_rdy_i = NE'($urandom());   // Engines ready at random
    end

    // ============================================================
    // Scoreboard
    // ============================================================
    task automatic expect_cfg(input int e, output logic [CFG_W-1:0] cfg);
        int found;
        int a;
        found = 0;
        a     = scan[e];
        cfg   = '0;
        while (found < NW && a < DEPTH) begin
            if (img[a][OW-1:0] == OW'(e + 1)) begin
                cfg[found*PW +: PW] = img[a][DW-1:OW];
                found++;
            end
            a++;
        end
        scan[e] = a;   // Next configuration continues from here
    endtask

    always @(posedge clk) begin : scoreboard
        int                 eng;
        int                 cand;
        int                 hs_cnt;
        logic [CFG_W-1:0]   exp_cfg;
        cand = -1;
        for (int i = NE - 1; i >= 0; i--) begin
            if (cfg_rdy_i[i] && !cfg_vld_o[i]) begin
                cand = i;
            end
        end
        eng    = cur_eng;
        hs_cnt = 0;
        if (isa_rd_addr_vld_o && !prev_addr_vld && need_grant) begin
            need_grant <= 1'b0;
            assert (cand_q >= 0) else begin
                errors++;
                $display("Address issued at %0t while no engine was ready", $time);
            end
            if (cand_q >= 0) begin
                eng = cand_q;
                assert (isa_rd_addr_o == sb_ptr[eng]) else begin
                    errors++;
                    $display("MISMATCH at %0t: grant address %0d, expected %0d of engine %0d",
                             $time, isa_rd_addr_o, sb_ptr[eng], eng);
                end
            end
        end
        if (isa_rd_addr_vld_o && isa_rd_addr_rdy_i && !hdr_wait) begin
            sb_ptr[eng] <= sb_ptr[eng] + 1'b1;
        end
        if (hdr_wait && isa_rd_dat_vld_i && isa_rd_dat_rdy_o) begin
            hdr_wait   <= 1'b0;
            need_grant <= (cur_cnt != 0);
        end
        if (|(cfg_vld_o & ~prev_cfg_vld)) begin
            need_grant <= 1'b1;   // A filled slot sends the FSM back to ARB
        end
        for (int e = 0; e < NE; e++) begin
            if (cfg_vld_o[e] && cfg_rdy_i[e]) begin
                expect_cfg(e, exp_cfg);
                hs_cnt++;
                assert (cfg_data_o[e] == exp_cfg) else begin
                    errors++;
                    $display("MISMATCH at %0t: engine %0d configuration %h, expected %h",
                             $time, e, cfg_data_o[e], exp_cfg);
                end
            end
        end
        handoffs <= handoffs + hs_cnt;
        if (eng_rst_o) begin
            for (int e = 0; e < NE; e++) begin
                sb_ptr[e] <= AW'(1);
            end
        end
        if (start_i && eng_rst_o) begin
            hdr_wait   <= 1'b1;
            need_grant <= 1'b0;
            handoffs   <= 0;
            for (int e = 0; e < NE; e++) begin
                scan[e] = 1;
            end
        end
        cur_eng       <= eng;
        cand_q        <= cand;
        prev_addr_vld <= isa_rd_addr_vld_o;
        prev_cfg_vld  <= cfg_vld_o;
    end

    always_comb begin
        sb_min = sb_ptr[0];
        for (int i = 1; i < NE; i++) begin
            if (sb_ptr[i] < sb_min) begin
                sb_min = sb_ptr[i];
            end
        end
    end

    // ============================================================
    // Protocol and completion checks
    // ============================================================
    a_idle_after_done: assert property (@(posedge clk) disable iff (!rst_n)
        net_done_o |=> !net_done_o && !isa_rd_addr_vld_o && !isa_rd_dat_rdy_o
                       && cfg_vld_o == '0 && eng_rst_o)
        else begin
            errors++;
            $display("MISMATCH at %0t: outputs not idle after done", $time);
        end

    a_done_count: assert property (@(posedge clk) disable iff (!rst_n)
        net_done_o |-> handoffs == cur_cnt)
        else begin
            errors++;
            $display("MISMATCH at %0t: %0d handoffs at done, expected %0d",
                     $time, handoffs, cur_cnt);
        end

    a_hdr_addr: assert property (@(posedge clk) disable iff (!rst_n)
        start_i && eng_rst_o |=> isa_rd_addr_vld_o && isa_rd_addr_o == '0)
        else begin
            errors++;
            $display("MISMATCH at %0t: no header read at address 0 after start", $time);
        end

    a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        isa_rd_addr_vld_o && !isa_rd_addr_rdy_i |=> isa_rd_addr_vld_o && $stable(isa_rd_addr_o))
        else begin
            errors++;
            $display("Address valid dropped or address changed before its transfer at %0t",
                     $time);
        end

    a_one_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        isa_rd_addr_vld_o && isa_rd_addr_rdy_i |-> !ram_pending)
        else begin
            errors++;
            $display("New address accepted at %0t before the previous data returned", $time);
        end

    a_min_ptr: assert property (@(posedge clk) disable iff (!rst_n)
        isa_rd_addr_min_o == sb_min)
        else begin
            errors++;
            $display("MISMATCH at %0t: minimum pointer %0d, expected %0d",
                     $time, isa_rd_addr_min_o, sb_min);
        end

    for (genvar e = 0; e < NE; e++) begin : g_cfg_chk
        a_cfg_hold: assert property (@(posedge clk) disable iff (!rst_n)
            cfg_vld_o[e] && !cfg_rdy_i[e] |=> cfg_vld_o[e] && $stable(cfg_data_o[e]))
            else begin
                errors++;
                $display("Engine %0d valid dropped or data changed before handoff at %0t",
                         e, $time);
            end
    end

    // ============================================================
    // Stimulus
    // ============================================================
    task automatic build_image(input int cnt, output int len);
        int            pos;
        int            j;
        int            tmp;
        int            order [NE];
        logic [PW-1:0] pl;
        for (int a = 0; a < DEPTH; a++) begin
            img[a] = {PW'(a * 32'h9e37_79b9), 8'hEE};   // Unused opcode everywhere
        end
        img[0] = {{(PW - CNT_W){1'b0}}, CNT_W'(cnt), OW'(0)};
        pos = 1;
        for (int r = 0; r < cnt * NW; r++) begin
            for (int i = 0; i < NE; i++) begin
                order[i] = i + 1;
            end
            for (int i = NE - 1; i > 0; i--) begin
                j        = $urandom_range(i, 0);
                tmp      = order[i];
                order[i] = order[j];
                order[j] = tmp;
            end
            for (int i = 0; i < NE; i++) begin
                if ($urandom_range(2, 0) == 0) begin
                    pl       = {$urandom(), 24'($urandom())};
                    img[pos] = {pl, (($urandom_range(1, 0) == 0) ? 8'h5A : 8'hC3)};
                    pos++;
                end
                pl       = {$urandom(), 24'($urandom())};
                img[pos] = {pl, OW'(order[i])};
                pos++;
            end
        end
        len = pos;
    endtask

    task automatic check_idle(input string where);
        assert (!isa_rd_addr_vld_o && !isa_rd_dat_rdy_o && cfg_vld_o == '0
                && !net_done_o && eng_rst_o) else begin
            errors++;
            $display("MISMATCH at %0t: outputs not in idle state %s", $time, where);
        end
    endtask

    task automatic run_test(input int idx, input int cnt, inout int failed);
        int err_start;
        int len;
        err_start = errors;
        build_image(cnt, len);
        cur_cnt = cnt;
        @(posedge clk);
        #2 start_i = 1'b1;
        @(posedge clk);
        #2 start_i = 1'b0;
        do @(posedge clk); while (!net_done_o);
        @(posedge clk);
        @(posedge clk);
        if (errors != err_start) begin
            failed++;
        end
        $display("Test %0d: header count %0d, %0d image words, %0d handoffs, %s",
                 idx, cnt, len, handoffs, (errors == err_start) ? "ok" : "FAILED");
    endtask

    // Upper bound of instruction words over all tests
    function automatic int watchdog_cycles();
        int words;
        words = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            words += 1 + TEST_CNT[t] * NW * 2 * NE;
        end
        return 200 * words + 20;
    endfunction

    initial begin : watchdog
        repeat (watchdog_cycles()) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles());
        $display("Checks failed");
        $finish;
    end

    initial begin : main
        int failed;
        failed = 0;
        void'($urandom(32'hc9d7_a418));
        rst_n   = 1'b0;
        start_i = 1'b0;
        repeat (2) @(posedge clk);
        #2 rst_n = 1'b1;
        @(posedge clk);
        check_idle("after reset");
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t, TEST_CNT[t], failed);
        end
        $display("Tests %0d, passed %0d, failed %0d, errors %0d",
                 NUM_TESTS, NUM_TESTS - failed, failed, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: ccu_top.f
+incdir+hw
hw/ccu_pkg.sv
hw/ccu_addr_min.sv
hw/ccu_cfg_slot.sv
hw/ccu_fetch_ctrl.sv
hw/ccu_top.sv
bench/ccu_tb.sv

// File: hw/ccu_addr_min.sv
// Smallest read pointer over all slots
// Purely combinational, unused leaves of the tree are padded with all ones

`timescale 1ns/1ps
`include "ccu_defines.svh"

module ccu_addr_min (
    input  ccu_pkg::isa_addr_t [`CCU_NUM_ENG-1:0] ptr_i,
    output ccu_pkg::isa_addr_t                    min_o
);

    localparam int LEVELS = $clog2(`CCU_NUM_ENG);
    localparam int LEAVES = 1 << LEVELS;

    // Heap layout, node 0 is the root and leaves start at LEAVES-1
    ccu_pkg::isa_addr_t node [2*LEAVES-1];

    // ============================================================
    // Leaves
    // ============================================================
    for (genvar l = 0; l < LEAVES; l++) begin : g_leaf
        if (l < `CCU_NUM_ENG) begin : g_used
            assign node[LEAVES-1+l] = ptr_i[l];
        end else begin : g_pad
            assign node[LEAVES-1+l] = '1;
        end
    end

    // ============================================================
    // Comparison tree
    // ============================================================
    for (genvar n = 0; n < LEAVES - 1; n++) begin : g_node
        assign node[n] = (node[2*n+1] <= node[2*n+2]) ? node[2*n+1] : node[2*n+2];
    end

    assign min_o = node[0];

endmodule

// File: hw/ccu_cfg_slot.sv
// One engine slot of the configuration control unit
// Keeps only words whose opcode equals ENG_CODE and collects NUM_WORDS of them
// The read pointer survives handoffs and restarts at 1 only when the unit is idle
// Strobes must not arrive while a configuration waits for its engine

`timescale 1ns/1ps
`include "ccu_defines.svh"

module ccu_cfg_slot #(
    parameter ccu_pkg::opcode_t ENG_CODE  = 8'd1,
    parameter int               NUM_WORDS = `CCU_CFG_WORDS
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                unit_idle_i,
    input  logic                                sel_i,
    input  logic                                addr_take_i,
    input  logic                                word_strobe_i,
    input  ccu_pkg::isa_word_t                  word_i,
    input  logic                                cfg_rdy_i,
    output ccu_pkg::isa_addr_t                  ptr_o,
    output logic                                filled_o,
    output logic                                cfg_vld_o,
    output ccu_pkg::payload_t [NUM_WORDS-1:0]   cfg_data_o
);

    // ============================================================
    // Local constants
    // ============================================================
    localparam int                  WCNT_W    = (NUM_WORDS > 1) ? $clog2(NUM_WORDS) : 1;
    localparam logic [WCNT_W-1:0]   LAST_WORD = WCNT_W'(NUM_WORDS - 1);
    localparam ccu_pkg::isa_addr_t  PTR_START = ccu_pkg::isa_addr_t'(1);  // Word 0 is the header

    ccu_pkg::isa_addr_t                ptr_q;
    logic [WCNT_W-1:0]                 wcnt_q;
    logic                              vld_q;
    ccu_pkg::payload_t [NUM_WORDS-1:0] data_q;
    ccu_pkg::opcode_t                  opcode;
    ccu_pkg::payload_t                 payload;
    logic                              hit;
    logic                              last;

    assign opcode  = word_i[`CCU_OPCODE_W-1:0];
    assign payload = word_i[`CCU_ISA_WORD_W-1:`CCU_OPCODE_W];
    assign hit     = sel_i & word_strobe_i & (opcode == ENG_CODE);
    assign last    = (wcnt_q == LAST_WORD);

    // ============================================================
    // Read pointer
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr_q <= PTR_START;
        end else if (unit_idle_i) begin
            ptr_q <= PTR_START;
        end else if (sel_i && addr_take_i) begin
            ptr_q <= ptr_q + 1'b1;     // Advances on every address, match or not
        end
    end

    // ============================================================
    // Word collection
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wcnt_q <= '0;
        end else if (unit_idle_i) begin
            wcnt_q <= '0;              // Drop a partial configuration
        end else if (hit) begin
            wcnt_q <= last ? '0 : wcnt_q + 1'b1;
        end
    end

    // Payload storage, word 0 lowest
    always_ff @(posedge clk) begin
        if (hit) begin
            data_q[wcnt_q] <= payload;
        end
    end

    // ============================================================
    // Handoff to the engine
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= 1'b0;
        end else if (unit_idle_i) begin
            vld_q <= 1'b0;
        end else if (vld_q && cfg_rdy_i) begin
            vld_q <= 1'b0;
        end else if (hit && last) begin
            vld_q <= 1'b1;
        end
    end

    assign ptr_o      = ptr_q;
    assign filled_o   = vld_q;         // Complete and not yet accepted
    assign cfg_vld_o  = vld_q;
    assign cfg_data_o = data_q;

endmodule

// File: hw/ccu_defines.svh
// Widths and counts shared by the configuration control unit
// The opcode sits in the lowest bits of every instruction word
// The header count lives in the payload bits just above the opcode

`ifndef CCU_DEFINES_SVH
`define CCU_DEFINES_SVH

// ============================================================
// Instruction RAM
// ============================================================
`define CCU_ISA_ADDR_W 10
`define CCU_ISA_WORD_W 64

// ============================================================
// Instruction word fields
// ============================================================
`define CCU_OPCODE_W   8
`define CCU_PAYLOAD_W  (`CCU_ISA_WORD_W - `CCU_OPCODE_W)   // 56 bits above the opcode

// ============================================================
// Engines and configurations
// ============================================================
`define CCU_NUM_ENG    4    // Slot e accepts opcode e+1
`define CCU_CFG_WORDS  2    // Payload words per configuration
`define CCU_CNT_W      8    // Configuration count in the header

`endif

// File: hw/ccu_fetch_ctrl.sv
// Controller of the configuration control unit
// Only one instruction read is in flight at any time
// The header opcode is not checked and its count sits above the opcode
// A header count of zero finishes without touching any slot

`timescale 1ns/1ps
`include "ccu_defines.svh"

module ccu_fetch_ctrl (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  start_i,
    // Instruction RAM address channel
    output ccu_pkg::isa_addr_t                    isa_rd_addr_o,
    output logic                                  isa_rd_addr_vld_o,
    input  logic                                  isa_rd_addr_rdy_i,
    // Instruction RAM data channel
    input  ccu_pkg::isa_word_t                    isa_rd_dat_i,
    input  logic                                  isa_rd_dat_vld_i,
    output logic                                  isa_rd_dat_rdy_o,
    // Slots and engines
    input  ccu_pkg::isa_addr_t [`CCU_NUM_ENG-1:0] slot_ptr_i,
    input  logic [`CCU_NUM_ENG-1:0]               slot_filled_i,
    input  logic [`CCU_NUM_ENG-1:0]               cfg_rdy_i,
    output logic [`CCU_NUM_ENG-1:0]               slot_sel_o,
    output logic                                  addr_take_o,
    output logic                                  word_strobe_o,
    output ccu_pkg::isa_word_t                    word_o,
    output logic                                  unit_idle_o,
    output logic                                  eng_rst_o,
    output logic                                  net_done_o
);

    ccu_pkg::ctrl_state_e state_q;
    ccu_pkg::ctrl_state_e state_d;
    ccu_pkg::eng_idx_t    grant_q;
    ccu_pkg::eng_idx_t    arb_idx;
    logic                 arb_hit;
    ccu_pkg::cfg_cnt_t    hdr_cnt_q;
    ccu_pkg::cfg_cnt_t    hdr_cnt_w;
    ccu_pkg::cfg_cnt_t    issued_q;
    logic                 all_issued;
    logic                 addr_hs;
    logic                 dat_hs;
    logic                 grant_filled;

    assign addr_hs      = isa_rd_addr_vld_o & isa_rd_addr_rdy_i;
    assign dat_hs       = isa_rd_dat_vld_i & isa_rd_dat_rdy_o;
    assign hdr_cnt_w    = isa_rd_dat_i[`CCU_OPCODE_W +: `CCU_CNT_W];
    assign all_issued   = (issued_q == hdr_cnt_q);
    assign grant_filled = slot_filled_i[grant_q];

    // ============================================================
    // Fixed priority arbiter, lowest index wins
    // ============================================================
    always_comb begin
        arb_hit = 1'b0;
        arb_idx = '0;
        for (int i = `CCU_NUM_ENG - 1; i >= 0; i--) begin
            if (cfg_rdy_i[i] && !slot_filled_i[i]) begin
                arb_hit = 1'b1;
                arb_idx = ccu_pkg::eng_idx_t'(i);
            end
        end
    end

    // ============================================================
    // FSM
    // ============================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            ccu_pkg::IDLE: begin
                if (start_i) begin
                    state_d = ccu_pkg::HDR_ADDR;
                end
            end
            ccu_pkg::HDR_ADDR: begin
                if (addr_hs) begin
                    state_d = ccu_pkg::HDR_DAT;
                end
            end
            ccu_pkg::HDR_DAT: begin
                if (dat_hs) begin
                    state_d = (hdr_cnt_w == '0) ? ccu_pkg::NET_DONE : ccu_pkg::ARB;
                end
            end
            ccu_pkg::ARB: begin
                if (all_issued) begin
                    if (!(|slot_filled_i)) begin   // Last handoffs drained
                        state_d = ccu_pkg::NET_DONE;
                    end
                end else if (arb_hit) begin
                    state_d = ccu_pkg::RD_ADDR;
                end
            end
            ccu_pkg::RD_ADDR: begin
                if (addr_hs) begin
                    state_d = ccu_pkg::RD_DAT;
                end
            end
            ccu_pkg::RD_DAT: begin
                if (dat_hs) begin
                    state_d = ccu_pkg::WAIT_FILL;
                end
            end
            ccu_pkg::WAIT_FILL: begin
                state_d = grant_filled ? ccu_pkg::ARB : ccu_pkg::RD_ADDR;
            end
            ccu_pkg::NET_DONE: begin
                state_d = ccu_pkg::IDLE;
            end
            default: begin
                state_d = ccu_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ccu_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Grant is registered so the address stays put while valid is high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant_q <= '0;
        end else if (state_q == ccu_pkg::ARB && !all_issued && arb_hit) begin
            grant_q <= arb_idx;
        end
    end

    // ============================================================
    // Header count and issued configurations
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdr_cnt_q <= '0;
        end else if (state_q == ccu_pkg::HDR_DAT && dat_hs) begin
            hdr_cnt_q <= hdr_cnt_w;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issued_q <= '0;
        end else if (state_q == ccu_pkg::IDLE) begin
            issued_q <= '0;
        end else if (state_q == ccu_pkg::WAIT_FILL && grant_filled) begin
            issued_q <= issued_q + 1'b1;
        end
    end

    // ============================================================
    // RAM ports and slot strobes
    // ============================================================
    assign isa_rd_addr_vld_o = (state_q == ccu_pkg::HDR_ADDR) || (state_q == ccu_pkg::RD_ADDR);
    assign isa_rd_addr_o     = (state_q == ccu_pkg::RD_ADDR) ? slot_ptr_i[grant_q] : '0;  // Header at 0
    assign isa_rd_dat_rdy_o  = (state_q == ccu_pkg::HDR_DAT) || (state_q == ccu_pkg::RD_DAT);

    assign addr_take_o   = (state_q == ccu_pkg::RD_ADDR) && addr_hs;
    assign word_strobe_o = (state_q == ccu_pkg::RD_DAT) && dat_hs;
    assign word_o        = isa_rd_dat_i;   // Broadcast, only the selected slot looks

    always_comb begin
        slot_sel_o          = '0;
        slot_sel_o[grant_q] = 1'b1;
    end

    assign unit_idle_o = (state_q == ccu_pkg::IDLE);
    assign eng_rst_o   = (state_q == ccu_pkg::IDLE);
    assign net_done_o  = (state_q == ccu_pkg::NET_DONE);

endmodule

// File: hw/ccu_pkg.sv
// Types shared by the configuration control unit
// Widths come from the defines header

`include "ccu_defines.svh"

package ccu_pkg;

    // Vectors with a meaning of their own
    typedef logic [`CCU_ISA_ADDR_W-1:0]      isa_addr_t;
    typedef logic [`CCU_ISA_WORD_W-1:0]      isa_word_t;
    typedef logic [`CCU_OPCODE_W-1:0]        opcode_t;
    typedef logic [`CCU_PAYLOAD_W-1:0]       payload_t;
    typedef logic [$clog2(`CCU_NUM_ENG)-1:0] eng_idx_t;
    typedef logic [`CCU_CNT_W-1:0]           cfg_cnt_t;

    // Controller FSM
    typedef enum logic [2:0] {
        IDLE,        // Engines held in reset
        HDR_ADDR,    // Header address on the RAM port
        HDR_DAT,     // Waiting for the header word
        ARB,         // Pick the next engine
        RD_ADDR,     // Granted slot pointer on the RAM port
        RD_DAT,      // Waiting for the instruction word
        WAIT_FILL,   // Slot decides if its configuration is complete
        NET_DONE     // One cycle of completion
    } ctrl_state_e;

endpackage

// File: hw/ccu_top.sv
// Configuration control unit for a multi-engine accelerator
// Engine e receives configurations built from words with opcode e+1
// isa_rd_addr_min_o marks the lowest word that is still needed

`timescale 1ns/1ps
`include "ccu_defines.svh"

module ccu_top (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       start_i,
    output logic                                       net_done_o,
    // Instruction RAM
    output logic [`CCU_ISA_ADDR_W-1:0]                 isa_rd_addr_o,
    output logic                                       isa_rd_addr_vld_o,
    input  logic                                       isa_rd_addr_rdy_i,
    input  logic [`CCU_ISA_WORD_W-1:0]                 isa_rd_dat_i,
    input  logic                                       isa_rd_dat_vld_i,
    output logic                                       isa_rd_dat_rdy_o,
    output logic [`CCU_ISA_ADDR_W-1:0]                 isa_rd_addr_min_o,
    // Engines
    output logic                                       eng_rst_o,
    output logic [`CCU_NUM_ENG-1:0]                    cfg_vld_o,
    input  logic [`CCU_NUM_ENG-1:0]                    cfg_rdy_i,
    output logic [`CCU_NUM_ENG-1:0][`CCU_CFG_WORDS*`CCU_PAYLOAD_W-1:0] cfg_data_o
);

    // ============================================================
    // Controller to slot wiring
    // ============================================================
    logic [`CCU_NUM_ENG-1:0][`CCU_ISA_ADDR_W-1:0] slot_ptr;
    logic [`CCU_NUM_ENG-1:0]                      slot_filled;
    logic [`CCU_NUM_ENG-1:0]                      slot_sel;
    logic                                         addr_take;
    logic                                         word_strobe;
    logic [`CCU_ISA_WORD_W-1:0]                   word;
    logic                                         unit_idle;

    ccu_fetch_ctrl u_fetch_ctrl (
        .clk               (clk),
        .rst_n             (rst_n),
        .start_i           (start_i),
        .isa_rd_addr_o     (isa_rd_addr_o),
        .isa_rd_addr_vld_o (isa_rd_addr_vld_o),
        .isa_rd_addr_rdy_i (isa_rd_addr_rdy_i),
        .isa_rd_dat_i      (isa_rd_dat_i),
        .isa_rd_dat_vld_i  (isa_rd_dat_vld_i),
        .isa_rd_dat_rdy_o  (isa_rd_dat_rdy_o),
        .slot_ptr_i        (slot_ptr),
        .slot_filled_i     (slot_filled),
        .cfg_rdy_i         (cfg_rdy_i),
        .slot_sel_o        (slot_sel),
        .addr_take_o       (addr_take),
        .word_strobe_o     (word_strobe),
        .word_o            (word),
        .unit_idle_o       (unit_idle),
        .eng_rst_o         (eng_rst_o),
        .net_done_o        (net_done_o)
    );

    // ============================================================
    // Engine slots
    // ============================================================
    for (genvar g = 0; g < `CCU_NUM_ENG; g++) begin : g_slot
        ccu_cfg_slot #(
            .ENG_CODE  (`CCU_OPCODE_W'(g + 1)),   // Opcode 0 is the header
            .NUM_WORDS (`CCU_CFG_WORDS)
        ) u_slot (
            .clk           (clk),
            .rst_n         (rst_n),
            .unit_idle_i   (unit_idle),
            .sel_i         (slot_sel[g]),
            .addr_take_i   (addr_take),
            .word_strobe_i (word_strobe),
            .word_i        (word),
            .cfg_rdy_i     (cfg_rdy_i[g]),
            .ptr_o         (slot_ptr[g]),
            .filled_o      (slot_filled[g]),
            .cfg_vld_o     (cfg_vld_o[g]),
            .cfg_data_o    (cfg_data_o[g])
        );
    end

    // Overwrite guard for the loader
    ccu_addr_min u_addr_min (
        .ptr_i (slot_ptr),
        .min_o (isa_rd_addr_min_o)
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the configuration control unit testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module ccu_tb \
    -f ccu_top.f \
    -o ccu_sim

./obj_dir/ccu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log || ! grep -q "All checks passed" sim.log; then
    echo "Simulation FAILED, see sim.log"
    exit 1
fi
echo "Simulation passed"
